// ==== common/analogizer_cfg_pkg.sv ====
`default_nettype none

package analogizer_cfg_pkg;

	// --------------------
	// Bridge side
	// --------------------
	typedef logic [31:0] bridge_word_t;     // One bridge data word
	typedef logic [3:0]  cfg_index_t;       // Word index from address bits 3:0

	// --------------------
	// Settings word layout
	// --------------------
	localparam int GAME_TYPE_LSB = 0;       // Controller type, 5 bits
	localparam int ASSIGN_LSB    = 6;       // Controller assignment, 4 bits
	localparam int VMODE_LSB     = 10;      // Video mode, 4 bits
	localparam int BLANK_BIT     = 14;      // Pocket screen blanking
	localparam int OSD_BIT       = 15;      // OSD request
	localparam int BUSY_BIT      = 31;      // Busy flag in the top bit

	// Type 20 keeps pin configuration A although it sits above 15
	localparam logic [4:0] CONF_A_EXTRA_TYPE = 5'd20;

	// Analog output modes, 2 and up are parked here
	typedef enum logic [3:0] {
		MODE_RGBS     = 4'd0,
		MODE_RGSB     = 4'd1,               // Sync on green
		MODE_YPBPR    = 4'd2,
		MODE_YC_A     = 4'd3,
		MODE_YC_B     = 4'd4,
		MODE_SD_FIRST = 4'd5                // First scandoubler code
	} video_mode_e;

	// Decoded settings, 20 bits
	typedef struct packed {
		logic [4:0]  game_cont_type;
		logic [3:0]  cont_assignment;
		video_mode_e video_mode;
		logic        blank_screen;
		logic        osd_enable;
		logic        conf_b;            // 0 for pin config A, 1 for B
		logic [2:0]  sc_fx;             // Scanline effect code
		logic        busy;
	} settings_t;

endpackage

`default_nettype wire

// ==== common/analogizer_video_pkg.sv ====
`default_nettype none

package analogizer_video_pkg;

	// Colour bits per channel on the DAC
	localparam int DAC_W = 6;

	// --------------------
	// Pixel from the core
	// --------------------
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
		logic       hs;             // Normalised sync
		logic       vs;
		logic       hblank;
		logic       vblank;
	} pixel_t;                      // 28 bits

	// What the DAC and sync pins get
	typedef struct packed {
		logic [DAC_W-1:0] r;
		logic [DAC_W-1:0] g;
		logic [DAC_W-1:0] b;
		logic             sync_h;   // H sync pin, carries csync in RGBS
		logic             sync_v;   // V sync pin, carries csync in RGsB
		logic             blank_n;
	} dac_t;                        // 21 bits

	// --------------------
	// Cartridge port
	// --------------------
	// Values plus direction, 1 drives the pin
	typedef struct packed {
		logic [7:0] bank1;
		logic [7:0] bank2;
		logic [7:0] bank3;
		logic       bank1_dir;
		logic       bank2_dir;
		logic       bank3_dir;
	} cart_banks_t;                 // 27 bits

endpackage

`default_nettype wire

// ==== src/bridge/analogizer_bridge_regs.sv ====
`default_nettype none
`timescale 1ns/1ps

module analogizer_bridge_regs #(
	parameter logic [7:0] CFG_ADDR_PAGE = 8'hF7    // Address page of the adapter
) (
	input  wire                              i_clk,
	input  wire                              i_rst_apf,
	input  wire                              i_bridge_endian_little,
	input  wire [31:0]                       i_bridge_addr,
	input  wire                              i_bridge_rd,     // Single-cycle strobe
	input  wire                              i_bridge_wr,     // Single-cycle strobe
	input  analogizer_cfg_pkg::bridge_word_t i_bridge_wr_data,
	output analogizer_cfg_pkg::bridge_word_t o_bridge_rd_data,
	output analogizer_cfg_pkg::bridge_word_t o_settings_word
);

	// Reverse the four byte lanes
	function automatic analogizer_cfg_pkg::bridge_word_t swap_bytes(
		input analogizer_cfg_pkg::bridge_word_t w
	);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	analogizer_cfg_pkg::bridge_word_t settings_word;
	analogizer_cfg_pkg::bridge_word_t cfg_mem [1:15];   // Words 1 to 15, no reset
	analogizer_cfg_pkg::bridge_word_t rd_data;
	analogizer_cfg_pkg::bridge_word_t wr_word;
	analogizer_cfg_pkg::bridge_word_t rd_word;
	analogizer_cfg_pkg::cfg_index_t   idx;
	logic                             page_hit;
	logic                             idx_zero;

	// --------------------
	// Address decode
	// --------------------
	assign page_hit = (i_bridge_addr[31:24] == CFG_ADDR_PAGE);
	assign idx      = i_bridge_addr[3:0];
	assign idx_zero = (idx == 4'd0);          // Settings word slot

	// Host writes big-endian unless told otherwise
	assign wr_word = i_bridge_endian_little ? i_bridge_wr_data : swap_bytes(i_bridge_wr_data);

	// Settings word, visible to the decoder the cycle after the write
	always_ff @(posedge i_clk) begin
		if (i_rst_apf) begin
			settings_word <= '0;
		end else if (i_bridge_wr && page_hit && idx_zero) begin
			settings_word <= wr_word;
		end
	end

	// Remaining configuration words
	always_ff @(posedge i_clk) begin
		if (i_bridge_wr && page_hit && !idx_zero) begin
			cfg_mem[idx] <= wr_word;
		end
	end

	// --------------------
	// Read back
	// --------------------
	assign rd_word = idx_zero ? settings_word : cfg_mem[idx];

	always_ff @(posedge i_clk) begin
		if (i_rst_apf) begin
			rd_data <= '0;
		end else if (i_bridge_rd && page_hit) begin
			// Same lane order as the write, so a saved file reloads unchanged
			rd_data <= i_bridge_endian_little ? rd_word : swap_bytes(rd_word);
		end
	end

	assign o_bridge_rd_data = rd_data;      // Held until the next read
	assign o_settings_word  = settings_word;

endmodule

`default_nettype wire

// ==== src/bridge/analogizer_settings.sv ====
`default_nettype none
`timescale 1ns/1ps

module analogizer_settings (
	input  wire                              i_clk,
	input  wire                              i_rst_apf,
	input  analogizer_cfg_pkg::bridge_word_t i_settings_word,
	output analogizer_cfg_pkg::settings_t    o_settings
);

	analogizer_cfg_pkg::settings_t settings_q;
	logic [4:0] game_type;
	logic [3:0] vmode;
	logic [3:0] vmode_sd;       // Mode minus first scandoubler code
	logic       sd_mode;
	logic       conf_b;

	// --------------------
	// Field extraction
	// --------------------
	assign game_type = i_settings_word[analogizer_cfg_pkg::GAME_TYPE_LSB +: 5];
	assign vmode     = i_settings_word[analogizer_cfg_pkg::VMODE_LSB +: 4];

	assign sd_mode  = (vmode >= 4'(analogizer_cfg_pkg::MODE_SD_FIRST));
	assign vmode_sd = vmode - 4'(analogizer_cfg_pkg::MODE_SD_FIRST);

	// Types 0-15 plus the one extra type use pin config A
	assign conf_b = (game_type > 5'd15) && (game_type != analogizer_cfg_pkg::CONF_A_EXTRA_TYPE);

	always_ff @(posedge i_clk) begin
		if (i_rst_apf) begin
			settings_q <= '0;       // Mode RGBS, config A
		end else begin
			settings_q.game_cont_type  <= game_type;
			settings_q.cont_assignment <=
				i_settings_word[analogizer_cfg_pkg::ASSIGN_LSB +: 4];
			settings_q.video_mode      <= analogizer_cfg_pkg::video_mode_e'(vmode);
			settings_q.blank_screen    <= i_settings_word[analogizer_cfg_pkg::BLANK_BIT];
			settings_q.osd_enable      <= i_settings_word[analogizer_cfg_pkg::OSD_BIT];
			settings_q.conf_b          <= conf_b;
			settings_q.busy            <= i_settings_word[analogizer_cfg_pkg::BUSY_BIT];
			// Scanline code only changes on a scandoubler mode
			if (sd_mode) begin
				settings_q.sc_fx <= vmode_sd[2:0];
			end
		end
	end

	assign o_settings = settings_q;

endmodule

`default_nettype wire

// ==== src/video/sync_polarity_fix.sv ====
`default_nettype none
`timescale 1ns/1ps

module sync_polarity_fix #(
	parameter int SYNC_CNT_W = 32       // Wide enough for a whole frame
) (
	input  wire  i_clk,
	input  wire  i_sync,
	output logic o_sync
);

	logic                  sync_d1 = 1'b0;
	logic                  sync_d2 = 1'b0;
	logic [SYNC_CNT_W-1:0] cnt     = '0;
	logic                  pol     = 1'b0;   // 1 when the source sync is active low

	always_ff @(posedge i_clk) begin
		sync_d1 <= i_sync;
		sync_d2 <= sync_d1;
		// High time pulls the count down, low time pushes it up
		cnt <= sync_d2 ? (cnt - 1'b1) : (cnt + 1'b1);
		if (sync_d1 && !sync_d2) begin  // Rising edge of the delayed sync
			cnt <= '0;
			pol <= cnt[SYNC_CNT_W-1];  // Negative means mostly high
		end
	end

	assign o_sync = i_sync ^ pol;       // Live path, no added latency

endmodule

`default_nettype wire

// ==== src/video/pixel_capture.sv ====
`default_nettype none
`timescale 1ns/1ps

module pixel_capture (
	input  wire                          i_clk,
	input  wire                          i_rst_apf,
	input  wire                          i_ce_pix,
	input  wire  [7:0]                   i_r,
	input  wire  [7:0]                   i_g,
	input  wire  [7:0]                   i_b,
	input  wire                          i_hblank,
	input  wire                          i_vblank,
	input  wire                          i_hs,      // Already normalised
	input  wire                          i_vs,
	output analogizer_video_pkg::pixel_t o_pixel
);

	analogizer_video_pkg::pixel_t pix_q;
	logic                         ce_d;      // Enable seen at the previous edge
	logic                         ce_rise;

	// Capture once per pixel, whatever the enable width
	assign ce_rise = i_ce_pix && !ce_d;

	always_ff @(posedge i_clk) begin
		if (i_rst_apf) begin
			ce_d  <= 1'b0;
			pix_q <= '0;
		end else begin
			ce_d <= i_ce_pix;
			if (ce_rise) begin
				pix_q.r      <= i_r;
				pix_q.g      <= i_g;
				pix_q.b      <= i_b;
				pix_q.hs     <= i_hs;
				pix_q.vs     <= i_vs;
				pix_q.hblank <= i_hblank;
				pix_q.vblank <= i_vblank;
			end
		end
	end

	assign o_pixel = pix_q;

endmodule

`default_nettype wire

// ==== src/video/analog_out_select.sv ====
`default_nettype none
`timescale 1ns/1ps

module analog_out_select (
	input  wire                               i_rst_apf,
	input  wire                               i_ena,      // Adapter enabled
	input  analogizer_video_pkg::pixel_t      i_pixel,
	input  analogizer_cfg_pkg::settings_t     i_settings,
	output analogizer_video_pkg::cart_banks_t o_cart
);

	localparam int DW = analogizer_video_pkg::DAC_W;

	analogizer_video_pkg::dac_t dac;
	logic [DW-1:0] r_top;
	logic [DW-1:0] g_top;
	logic [DW-1:0] b_top;
	logic          de;          // Data enable
	logic          csync;
	logic          park;

	// --------------------
	// Video prep
	// --------------------
	assign de    = !(i_pixel.hblank || i_pixel.vblank);
	assign csync = !(i_pixel.hs ^ i_pixel.vs);            // Composite sync
	// Top DAC bits only, blacked out during blanking
	assign r_top = i_pixel.r[7 -: DW] & {DW{de}};
	assign g_top = i_pixel.g[7 -: DW] & {DW{de}};
	assign b_top = i_pixel.b[7 -: DW] & {DW{de}};

	always_comb begin
		dac.blank_n = de;
		dac.sync_v  = 1'b1;
		case (i_settings.video_mode)
			analogizer_cfg_pkg::MODE_RGBS: begin
				dac.r      = r_top;
				dac.g      = g_top;
				dac.b      = b_top;
				dac.sync_h = csync;            // Csync on the H pin
			end
			analogizer_cfg_pkg::MODE_RGSB: begin
				dac.r      = r_top;
				dac.g      = g_top;
				dac.b      = b_top;
				dac.sync_h = 1'b1;
				dac.sync_v = csync;            // DAC sync pin, SOG switch on
			end
			default: begin
				// Parked modes keep only the H sync alive
				dac.r      = '0;
				dac.g      = '0;
				dac.b      = '0;
				dac.sync_h = i_pixel.hs;
			end
		endcase
	end

	// --------------------
	// Cartridge banks
	// --------------------
	assign park = i_rst_apf || !i_ena;   // Pins left as inputs

	always_comb begin
		if (park) begin
			o_cart = '0;
		end else begin
			o_cart.bank3     = {dac.r, dac.sync_h, dac.sync_v};
			o_cart.bank2     = {dac.b[0], dac.blank_n, dac.g};
			// Bits 7:6 unused, bit 5 is the video clock held low
			o_cart.bank1     = {2'b00, 1'b0, dac.b[DW-1:1]};
			o_cart.bank1_dir = 1'b1;
			o_cart.bank2_dir = 1'b1;
			o_cart.bank3_dir = 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== src/analogizer_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module analogizer_top #(
	parameter logic [7:0] CFG_ADDR_PAGE = 8'hF7,
	parameter int         SYNC_CNT_W    = 32
) (
	input  wire                               i_clk,
	input  wire                               i_rst_apf,
	input  wire                               i_ena,
	// Bridge
	input  wire                               i_bridge_endian_little,
	input  wire  [31:0]                       i_bridge_addr,
	input  wire                               i_bridge_rd,
	input  wire                               i_bridge_wr,
	input  analogizer_cfg_pkg::bridge_word_t  i_bridge_wr_data,
	// Core video
	input  wire                               i_ce_pix,
	input  wire  [7:0]                        i_r,
	input  wire  [7:0]                        i_g,
	input  wire  [7:0]                        i_b,
	input  wire                               i_hblank,
	input  wire                               i_vblank,
	input  wire                               i_hsync,    // Either polarity
	input  wire                               i_vsync,
	output analogizer_cfg_pkg::bridge_word_t  o_bridge_rd_data,
	output analogizer_cfg_pkg::settings_t     o_settings,
	output analogizer_video_pkg::cart_banks_t o_cart
);

	analogizer_cfg_pkg::bridge_word_t settings_word;
	analogizer_cfg_pkg::settings_t    settings;
	analogizer_video_pkg::pixel_t     pixel;
	logic                             hs_fix;
	logic                             vs_fix;

	// --------------------
	// Configuration
	// --------------------
	analogizer_bridge_regs #(.CFG_ADDR_PAGE(CFG_ADDR_PAGE)) u_bridge_regs (
		.i_clk(i_clk), .i_rst_apf(i_rst_apf),
		.i_bridge_endian_little(i_bridge_endian_little),
		.i_bridge_addr(i_bridge_addr), .i_bridge_rd(i_bridge_rd),
		.i_bridge_wr(i_bridge_wr), .i_bridge_wr_data(i_bridge_wr_data),
		.o_bridge_rd_data(o_bridge_rd_data), .o_settings_word(settings_word)
	);

	analogizer_settings u_settings (
		.i_clk(i_clk), .i_rst_apf(i_rst_apf),
		.i_settings_word(settings_word), .o_settings(settings)
	);

	// --------------------
	// Video path
	// --------------------
	sync_polarity_fix #(.SYNC_CNT_W(SYNC_CNT_W)) u_hs_fix (
		.i_clk(i_clk), .i_sync(i_hsync), .o_sync(hs_fix)
	);
	sync_polarity_fix #(.SYNC_CNT_W(SYNC_CNT_W)) u_vs_fix (
		.i_clk(i_clk), .i_sync(i_vsync), .o_sync(vs_fix)
	);

	pixel_capture u_pixel_capture (
		.i_clk(i_clk), .i_rst_apf(i_rst_apf), .i_ce_pix(i_ce_pix),
		.i_r(i_r), .i_g(i_g), .i_b(i_b),
		.i_hblank(i_hblank), .i_vblank(i_vblank),
		.i_hs(hs_fix), .i_vs(vs_fix), .o_pixel(pixel)
	);

	analog_out_select u_out_select (
		.i_rst_apf(i_rst_apf), .i_ena(i_ena),
		.i_pixel(pixel), .i_settings(settings), .o_cart(o_cart)
	);

	assign o_settings = settings;

endmodule

`default_nettype wire

// ==== tb/tb_analogizer_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_analogizer_top;

	localparam logic [1:0]  K_WR      = 2'd0;     // Bridge write
	localparam logic [1:0]  K_RD      = 2'd1;     // Bridge read, compare read data
	localparam logic [1:0]  K_PIX     = 2'd2;     // One captured pixel, compare banks
	localparam logic [1:0]  K_SET     = 2'd3;     // Compare decoded settings
	localparam logic [31:0] PAGE      = 32'hF700_0000;
	localparam int          LINE_LEN  = 64;       // Cycles per sync line
	localparam int          PULSE_LEN = 6;        // Short active-low hsync pulse
	// Pixel flags {vs, hs, vblank, hblank}, five per mode
	localparam logic [19:0] PIX_FLAGS = {4'b1100, 4'b1000, 4'b0110, 4'b0001, 4'b0000};

	typedef struct packed {
		logic [1:0]  kind;
		logic [31:0] addr;        // Pixel entries keep the active mode here
		logic [31:0] data;        // Pixel entries keep the flags here
		logic        endian;      // 1 for little-endian
		logic [31:0] expected;
	} entry_t;

	logic        i_clk = 1'b0;
	logic        i_rst_apf;
	logic        i_ena;
	logic        i_bridge_endian_little;
	logic [31:0] i_bridge_addr;
	logic        i_bridge_rd;
	logic        i_bridge_wr;
	logic [31:0] i_bridge_wr_data;
	logic        i_ce_pix;
	logic [7:0]  i_r;
	logic [7:0]  i_g;
	logic [7:0]  i_b;
	logic        i_hblank;
	logic        i_vblank;
	logic        i_hsync;
	logic        i_vsync;
	logic [31:0] o_bridge_rd_data;
	analogizer_cfg_pkg::settings_t     o_settings;
	analogizer_video_pkg::cart_banks_t o_cart;

	entry_t tbl [$];                  // Stimulus table
	integer seed        = 32'h4229a9c0;
	int     errors      = 0;
	int     checks      = 0;
	int     tests       = 0;
	int     cycle_cnt   = 0;
	int     cycle_limit = 2000;       // Raised once the table is built

	analogizer_top #(.CFG_ADDR_PAGE(8'hF7), .SYNC_CNT_W(32)) i_analogizer_top (
		.i_clk(i_clk), .i_rst_apf(i_rst_apf), .i_ena(i_ena),
		.i_bridge_endian_little(i_bridge_endian_little),
		.i_bridge_addr(i_bridge_addr), .i_bridge_rd(i_bridge_rd),
		.i_bridge_wr(i_bridge_wr), .i_bridge_wr_data(i_bridge_wr_data),
		.i_ce_pix(i_ce_pix), .i_r(i_r), .i_g(i_g), .i_b(i_b),
		.i_hblank(i_hblank), .i_vblank(i_vblank),
		.i_hsync(i_hsync), .i_vsync(i_vsync),
		.o_bridge_rd_data(o_bridge_rd_data), .o_settings(o_settings), .o_cart(o_cart)
	);

	always #10 i_clk = ~i_clk;        // 20 ns period

	// Run limit
	always @(posedge i_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == cycle_limit) begin
			$display("Timeout: run stopped after %0d cycles", cycle_cnt);
			$display("Testbench failed");
			$finish;
		end
	end

	// --------------------
	// Checks and table
	// --------------------
	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] t=%0t ns %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		tests++;
		$display("test %0d %s: %s", tests, name, (errors == err_before) ? "ok" : "FAIL");
	endtask

	task automatic add_entry(input logic [1:0] kind, input logic [31:0] addr,
			input logic [31:0] data, input logic endian, input logic [31:0] expected);
		tbl.push_back('{kind, addr, data, endian, expected});
	endtask

	// Write a settings word, then expect the decoded fields
	task automatic add_settings_test(input logic [4:0] t, input logic [3:0] a,
			input logic [3:0] m, input logic bl, input logic osd, input logic busy,
			input logic cb, input logic [2:0] sc);
		logic [31:0] w;
		w = '0;
		w[4:0]   = t;                 // Controller type
		w[9:6]   = a;                 // Assignment
		w[13:10] = m;                 // Video mode
		w[14]    = bl;
		w[15]    = osd;
		w[31]    = busy;
		add_entry(K_WR, PAGE, w, 1'b1, 32'd0);
		add_entry(K_SET, PAGE, 32'd0, 1'b1, {12'b0, t, a, m, bl, osd, cb, sc, busy});
	endtask

	task automatic build_table();
		logic [31:0] w;
		int          k;
		int          m;
		add_entry(K_SET, PAGE, 32'd0, 1'b1, 32'd0);         // Reset value
		add_settings_test(5'd3, 4'd2, 4'd0, 1'b1, 1'b0, 1'b0, 1'b0, 3'd0);
		add_settings_test(5'd15, 4'd9, 4'd1, 1'b0, 1'b1, 1'b1, 1'b0, 3'd0);
		add_settings_test(5'd16, 4'd5, 4'd6, 1'b0, 1'b0, 1'b0, 1'b1, 3'd1);
		add_settings_test(5'd20, 4'd15, 4'd0, 1'b1, 1'b1, 1'b0, 1'b0, 3'd1); // sc_fx held
		add_settings_test(5'd31, 4'd0, 4'd12, 1'b0, 1'b0, 1'b1, 1'b1, 3'd7);
		add_settings_test(5'd21, 4'd3, 4'd0, 1'b0, 1'b0, 1'b0, 1'b1, 3'd7);
		// Settings word through both byte orders
		add_entry(K_WR, PAGE, 32'h1234_5678, 1'b1, 32'd0);
		add_entry(K_RD, PAGE, 32'd0, 1'b1, 32'h1234_5678);
		add_entry(K_WR, PAGE, 32'hA1B2_C3D4, 1'b0, 32'd0);
		add_entry(K_RD, PAGE, 32'd0, 1'b0, 32'hA1B2_C3D4);
		add_entry(K_RD, PAGE, 32'd0, 1'b1, 32'hD4C3_B2A1);  // Lanes reversed
		// Memory words, pattern spread over the whole index
		for (k = 1; k < 16; k++) begin
			w = 32'h9E37_79B9 * k;
			add_entry(K_WR, PAGE | k, w, w[0], 32'd0);
		end
		for (k = 1; k < 16; k++) begin
			w = 32'h9E37_79B9 * k;
			add_entry(K_RD, PAGE | k, 32'd0, w[0], w);   // Same order as written
		end
		// RGBS, RGsB, then a parked mode, sc_fx still 7 from mode 12
		for (m = 0; m < 3; m++) begin
			add_settings_test(5'd0, 4'd0, 4'(m), 1'b0, 1'b0, 1'b0, 1'b0, 3'd7);
			for (k = 0; k < 5; k++) begin
				add_entry(K_PIX, 32'(m), {28'b0, PIX_FLAGS[k*4 +: 4]}, 1'b0, 32'd0);
			end
		end
	endtask

	// Bank image from the mode table and the pin mapping
	function automatic logic [26:0] expect_cart(input logic [3:0] mode,
			input logic [7:0] r, input logic [7:0] g, input logic [7:0] b,
			input logic hb, input logic vb, input logic hs, input logic vs);
		logic       de;
		logic       cs;
		logic       sh;
		logic       sv;
		logic [5:0] rr;
		logic [5:0] gg;
		logic [5:0] bb;
		de = !(hb || vb);
		cs = (hs == vs);              // Csync, XNOR
		rr = de ? r[7:2] : 6'd0;
		gg = de ? g[7:2] : 6'd0;
		bb = de ? b[7:2] : 6'd0;
		sh = cs;
		sv = 1'b1;
		if (mode == 4'd1) begin       // RGsB
			sh = 1'b1;
			sv = cs;
		end else if (mode != 4'd0) begin
			rr = '0;
			gg = '0;
			bb = '0;
			sh = hs;
		end
		return {3'b000, bb[5:1], bb[0], de, gg, rr, sh, sv, 3'b111};
	endfunction

	// --------------------
	// Bus and video drivers
	// --------------------
	task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data,
			input logic endian);
		@(posedge i_clk);
		i_bridge_addr          <= addr;
		i_bridge_wr_data       <= data;
		i_bridge_endian_little <= endian;
		i_bridge_wr            <= 1'b1;
		@(posedge i_clk);             // Write taken here
		i_bridge_wr <= 1'b0;
		@(posedge i_clk);             // Fields settle one edge later
	endtask

	task automatic bridge_read(input logic [31:0] addr, input logic endian);
		@(posedge i_clk);
		i_bridge_addr          <= addr;
		i_bridge_endian_little <= endian;
		i_bridge_rd            <= 1'b1;
		@(posedge i_clk);
		i_bridge_rd <= 1'b0;
		@(negedge i_clk);
	endtask

	task automatic drive_pixel(input logic [3:0] mode, input logic [3:0] flags);
		logic [31:0] rnd_r;
		logic [31:0] rnd_g;
		logic [31:0] rnd_b;
		rnd_r = $random(seed);
		rnd_g = $random(seed);
		rnd_b = $random(seed);
		@(posedge i_clk);
		i_r      <= rnd_r[7:0];
		i_g      <= rnd_g[7:0];
		i_b      <= rnd_b[7:0];
		i_hblank <= flags[0];
		i_vblank <= flags[1];
		i_hsync  <= flags[2];
		i_vsync  <= flags[3];
		i_ce_pix <= 1'b1;
		@(posedge i_clk);             // Captured on this edge
		i_ce_pix <= 1'b0;
		i_hsync  <= 1'b0;             // Short high so polarity stays 0
		i_vsync  <= 1'b0;
		@(negedge i_clk);
		check_value("o_cart", {5'b0, o_cart}, {5'b0, expect_cart(mode, rnd_r[7:0],
			rnd_g[7:0], rnd_b[7:0], flags[0], flags[1], flags[2], flags[3])});
		repeat (2) @(posedge i_clk);  // Low gap before the next sync pulse
	endtask

	// Ten lines of active-low hsync, then look at the normalised pin
	task automatic hsync_polarity_test();
		int line;
		int c;
		bridge_write(PAGE, 32'h0000_0C00, 1'b1);    // Mode 3
		for (line = 0; line < 10; line++) begin
			for (c = 0; c < LINE_LEN; c++) begin
				@(posedge i_clk);
				i_hblank <= 1'b0;
				i_vblank <= 1'b0;
				i_hsync  <= (c >= PULSE_LEN);
				i_ce_pix <= c[0];
				if (line == 9 && c == 4) begin
					@(negedge i_clk);     // Pixel taken inside the pulse
					check_value("o_cart.bank3[1]", {31'b0, o_cart.bank3[1]}, 32'd1);
				end
				if (line == 9 && c == 40) begin
					@(negedge i_clk);
					check_value("o_cart.bank3[1]", {31'b0, o_cart.bank3[1]}, 32'd0);
				end
			end
		end
	endtask

	// --------------------
	// Main sequence
	// --------------------
	initial begin : main
		entry_t e;
		int     i;
		int     err_before;
		string  kname;
		i_rst_apf              = 1'b1;
		i_ena                  = 1'b1;
		i_bridge_endian_little = 1'b1;
		i_bridge_addr          = '0;
		i_bridge_rd            = 1'b0;
		i_bridge_wr            = 1'b0;
		i_bridge_wr_data       = '0;
		i_ce_pix               = 1'b0;
		i_r                    = '0;
		i_g                    = '0;
		i_b                    = '0;
		i_hblank               = 1'b0;
		i_vblank               = 1'b0;
		i_hsync                = 1'b0;
		i_vsync                = 1'b0;
		build_table();
		cycle_limit = tbl.size() * 8 + 2000 + 16;

		repeat (15) @(posedge i_clk);
		@(negedge i_clk);
		err_before = errors;
		check_value("o_cart", {5'b0, o_cart}, 32'd0);   // Parked in reset
		@(posedge i_clk);             // 16th edge ends reset
		i_rst_apf <= 1'b0;
		i_ena     <= 1'b0;
		@(negedge i_clk);
		check_value("o_cart", {5'b0, o_cart}, 32'd0);   // Parked while disabled
		report_test("reset and disable parking", err_before);
		@(posedge i_clk);
		i_ena <= 1'b1;

		for (i = 0; i < tbl.size(); i++) begin
			e          = tbl[i];
			err_before = errors;
			case (e.kind)
				K_WR: begin
					kname = "write";
					bridge_write(e.addr, e.data, e.endian);
				end
				K_RD: begin
					kname = "read";
					bridge_read(e.addr, e.endian);
					check_value("o_bridge_rd_data", o_bridge_rd_data, e.expected);
				end
				K_PIX: begin
					kname = "pixel";
					drive_pixel(e.addr[3:0], e.data[3:0]);
				end
				default: begin
					kname = "settings";
					@(negedge i_clk);
					check_value("o_settings", {12'b0, o_settings}, e.expected);
				end
			endcase
			report_test(kname, err_before);
		end

		err_before = errors;
		hsync_polarity_test();
		report_test("hsync polarity", err_before);

		$display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== analogizer_top.f ====
common/analogizer_cfg_pkg.sv
common/analogizer_video_pkg.sv
src/bridge/analogizer_bridge_regs.sv
src/bridge/analogizer_settings.sv
src/video/sync_polarity_fix.sv
src/video/pixel_capture.sv
src/video/analog_out_select.sv
src/analogizer_top.sv
tb/tb_analogizer_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the analogizer testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module tb_analogizer_top \
	-f analogizer_top.f -o sim_tb; then
	echo "Verilator build failed"
	exit 1
fi

if ! sim_out=$(./obj_dir/sim_tb 2>&1); then
	echo "$sim_out"
	echo "Simulation ended with an error status"
	exit 1
fi

echo "$sim_out"

# Pass only when the exact pass line shows up
if grep -qx "Testbench passed" <<< "$sim_out"; then
	exit 0
fi

echo "Pass line not found in the simulation output"
exit 1
